/* common/video_pkg.sv */
package video_pkg;

	// DRAM word address width
	localparam int VADDR_W = 21;

	// screen mode codes as written by the CPU, 6 and 7 are illegal
	typedef enum logic [2:0] {
		MODE_ZX      = 3'd0,
		MODE_P_HMCLR = 3'd1,
		MODE_P_16C   = 3'd2,
		MODE_A_16C   = 3'd3,
		MODE_A_HMCLR = 3'd4,
		MODE_A_TEXT  = 3'd5
	} mode_code_t;

	// decoded mode, exactly one flag set
	typedef struct packed {
		logic zx;       // standard spectrum screen
		logic p_16c;    // pentagon 16 colours
		logic p_hmclr;  // pentagon hardware multicolor
		logic a_gfx;    // atm 16c and atm multicolor share one sequence
		logic a_text;   // atm text
		logic scr_page; // which screen to fetch
	} video_mode_t;

	// one word back from DRAM
	typedef struct packed {
		logic [15:0] data;
		logic        kind; // 0 pixel or char, 1 attribute or second plane
	} fetch_word_t;

endpackage

/* source/video_apb_regs.sv */
`timescale 1ns/1ps

module video_apb_regs
	import video_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output mode_code_t  req_mode,
	output logic        req_page
);

	localparam logic [3:0] ADDR_MODE = 4'h0;
	localparam logic [3:0] ADDR_PAGE = 4'h4;

	logic access;
	logic sel_mode;
	logic sel_page;
	logic bad_code;
	logic bad_access;

	assign access   = psel & penable; // second cycle of the transfer
	assign sel_mode = (paddr == ADDR_MODE);
	assign sel_page = (paddr == ADDR_PAGE);

	// codes 6 and 7 have no screen mode behind them
	assign bad_code = (pwdata[2:1] == 2'b11);

	assign bad_access = ~(sel_mode | sel_page) | (pwrite & sel_mode & bad_code);

	assign pready  = 1'b1; // never waits
	assign pslverr = access & bad_access;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			req_mode <= MODE_ZX;
			req_page <= 1'b0;
		end
		else if (access && pwrite && !bad_access)
		begin
			if (sel_mode)
				req_mode <= mode_code_t'(pwdata[2:0]);
			if (sel_page)
				req_page <= pwdata[0];
		end
	end

	// read mux, unused bits read as zero
	always_comb
	begin
		prdata = 32'h0;
		if (sel_mode)
			prdata[2:0] = req_mode;
		else if (sel_page)
			prdata[0] = req_page;
	end

endmodule

/* video/video_mode_decode.sv */
`timescale 1ns/1ps

module video_mode_decode
	import video_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        int_start,
	input  mode_code_t  req_mode,
	input  logic        req_page,
	output video_mode_t mode
);

	localparam video_mode_t MODE_RESET = '{zx: 1'b1, default: 1'b0};

	video_mode_t decoded;

	// one-hot flags from the requested code
	always_comb
	begin
		decoded          = '0;
		decoded.scr_page = req_page;
		case (req_mode)
			MODE_ZX:
				decoded.zx = 1'b1;
			MODE_P_HMCLR:
				decoded.p_hmclr = 1'b1;
			MODE_P_16C:
				decoded.p_16c = 1'b1;
			MODE_A_16C, MODE_A_HMCLR:
				decoded.a_gfx = 1'b1; // same fetch order for both
			MODE_A_TEXT:
				decoded.a_text = 1'b1;
			default:
				decoded.zx = 1'b1;
		endcase
	end

	// new setting only takes effect at frame start
	always_ff @(posedge clk)
	begin
		if (reset)
			mode <= MODE_RESET;
		else if (int_start)
			mode <= decoded;
	end

endmodule

/* video/video_addrgen.sv */
`timescale 1ns/1ps

module video_addrgen
	import video_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               line_start,
	input  logic               int_start,
	input  logic               vpix,
	input  logic               video_next,
	input  video_mode_t        mode,
	output logic [VADDR_W-1:0] video_addr,
	output logic               kind_next,
	output logic [2:0]         typos
);

	localparam logic [5:0] ZX_PREFIX = 6'b000001;
	localparam logic [7:0] TY_START  = 8'h37; // first row wraps to 0x38

	logic line_start_r;
	logic frame_init_r;
	logic line_init_r;
	logic line_init;
	logic gnext;
	logic tnext;
	logic ldaddr;

	logic [13:0] gctr;  // graphics word counter
	logic [7:0]  tyctr; // text row counter
	logic [6:0]  txctr; // text column counter

	logic [11:0] zx_pix;
	logic [11:0] zx_attr;
	logic [11:0] p16c_pix;

	logic [VADDR_W-1:0] addr_zx;
	logic [VADDR_W-1:0] addr_phm;
	logic [VADDR_W-1:0] addr_p16c;
	logic [VADDR_W-1:0] addr_ag;
	logic [VADDR_W-1:0] addr_at;
	logic [VADDR_W-1:0] addr_sel;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			line_start_r <= 1'b0;
			frame_init_r <= 1'b0;
			line_init_r  <= 1'b0;
		end
		else
		begin
			line_start_r <= line_start;
			frame_init_r <= int_start;
			line_init_r  <= line_init;
		end
	end

	assign line_init = line_start_r & vpix; // only visible lines

	assign gnext  = video_next | frame_init_r;
	assign tnext  = video_next | line_init_r;
	assign ldaddr = mode.a_text ? tnext : gnext;

	always_ff @(posedge clk)
	begin
		if (reset || int_start)
			gctr <= '0;
		else if (gnext)
			gctr <= gctr + 14'd1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			tyctr <= '0;
		else if (int_start)
			tyctr <= TY_START;
		else if (line_init)
			tyctr <= tyctr + 8'd1;
	end

	always_ff @(posedge clk)
	begin
		if (reset || line_init)
			txctr <= '0;
		else if (tnext)
			txctr <= txctr + 7'd1;
	end

	assign typos = tyctr[2:0]; // row inside the glyph

	// gctr[0] picks pixel or attribute, [4:1] column, upper bits row
	assign zx_pix   = {gctr[12:11], gctr[7:5], gctr[10:8], gctr[4:1]};
	assign zx_attr  = {3'b110, gctr[12:8], gctr[4:1]};
	assign p16c_pix = {gctr[13:12], gctr[8:6], gctr[11:9], gctr[5:2]}; // one bit up

	assign addr_zx   = {ZX_PREFIX, mode.scr_page, 2'b10, (gctr[0] ? zx_attr : zx_pix)};
	assign addr_phm  = {ZX_PREFIX, mode.scr_page, 1'b1, gctr[0], zx_pix};
	assign addr_p16c = {ZX_PREFIX, mode.scr_page, ~gctr[0], gctr[1], p16c_pix};
	assign addr_ag   = {5'b00000, ~gctr[0], mode.scr_page, 1'b1, gctr[1], gctr[13:2]};
	assign addr_at   = {5'b00000, ~txctr[0], mode.scr_page, 1'b1, txctr[1], 2'b00,
		tyctr[7:3], txctr[6:2]};

	// flags are one-hot so a plain or of the masked addresses will do
	assign addr_sel = ({VADDR_W{mode.zx}}      & addr_zx)   |
		({VADDR_W{mode.p_16c}}   & addr_p16c) |
		({VADDR_W{mode.p_hmclr}} & addr_phm)  |
		({VADDR_W{mode.a_gfx}}   & addr_ag)   |
		({VADDR_W{mode.a_text}}  & addr_at);

	// kind travels with the address it belongs to
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			video_addr <= '0;
			kind_next  <= 1'b0;
		end
		else if (ldaddr)
		begin
			video_addr <= addr_sel;
			kind_next  <= mode.a_text ? txctr[0] : gctr[0];
		end
	end

endmodule

/* video/video_fetch.sv */
`timescale 1ns/1ps

module video_fetch
	import video_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic               clk,
	input  logic               reset,
	input  logic               fetch_en,
	input  logic [VADDR_W-1:0] video_addr,
	input  logic               kind_next,
	input  logic               dram_ack,
	input  logic               dram_rvalid,
	input  logic [15:0]        dram_rdata,
	output logic               dram_req,
	output logic [VADDR_W-1:0] dram_addr,
	output logic               video_next,
	output logic               word_valid,
	output fetch_word_t        word
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam logic [PTR_W:0] CNT_FULL = (PTR_W+1)'(QUEUE_DEPTH);

	logic             grant;
	logic [PTR_W:0]   inflight; // granted reads not yet returned
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             tag_mem [QUEUE_DEPTH];

	assign grant      = dram_req & dram_ack;
	assign video_next = grant; // address generator reloads on this
	assign dram_addr  = video_addr;

	// request drops for one cycle after each grant while the address reloads
	always_ff @(posedge clk)
	begin
		if (reset)
			dram_req <= 1'b0;
		else if (dram_req)
		begin
			if (dram_ack)
				dram_req <= 1'b0;
		end
		else
			dram_req <= fetch_en && (inflight < CNT_FULL);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			inflight <= '0;
		else
		begin
			case ({grant, dram_rvalid})
				2'b10:   inflight <= inflight + 1'b1;
				2'b01:   inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase
		end
	end

	// kind tags in grant order, returns come back in the same order
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (grant)
				wr_ptr <= wr_ptr + 1'b1;
			if (dram_rvalid)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (grant)
			tag_mem[wr_ptr] <= kind_next;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			word_valid <= 1'b0;
		else
			word_valid <= dram_rvalid;
	end

	always_ff @(posedge clk)
	begin
		if (dram_rvalid)
		begin
			word.data <= dram_rdata;
			word.kind <= tag_mem[rd_ptr];
		end
	end

endmodule

/* source/video_fetch_top.sv */
`timescale 1ns/1ps

module video_fetch_top
	import video_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic               clk,
	input  logic               reset,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [3:0]         paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	input  logic               line_start,
	input  logic               int_start,
	input  logic               vpix,
	input  logic               fetch_en,
	input  logic               dram_ack,
	input  logic               dram_rvalid,
	input  logic [15:0]        dram_rdata,
	output logic               dram_req,
	output logic [VADDR_W-1:0] dram_addr,
	output logic               word_valid,
	output fetch_word_t        word,
	output logic [2:0]         typos
);

	mode_code_t         req_mode;
	logic               req_page;
	video_mode_t        mode;
	logic [VADDR_W-1:0] video_addr;
	logic               kind_next;
	logic               video_next;

	video_apb_regs u_regs (
		.clk      (clk),
		.reset    (reset),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.req_mode (req_mode),
		.req_page (req_page)
	);

	video_mode_decode u_decode (
		.clk       (clk),
		.reset     (reset),
		.int_start (int_start),
		.req_mode  (req_mode),
		.req_page  (req_page),
		.mode      (mode)
	);

	video_addrgen u_addrgen (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.int_start  (int_start),
		.vpix       (vpix),
		.video_next (video_next),
		.mode       (mode),
		.video_addr (video_addr),
		.kind_next  (kind_next),
		.typos      (typos)
	);

	video_fetch #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_fetch (
		.clk         (clk),
		.reset       (reset),
		.fetch_en    (fetch_en),
		.video_addr  (video_addr),
		.kind_next   (kind_next),
		.dram_ack    (dram_ack),
		.dram_rvalid (dram_rvalid),
		.dram_rdata  (dram_rdata),
		.dram_req    (dram_req),
		.dram_addr   (dram_addr),
		.video_next  (video_next),
		.word_valid  (word_valid),
		.word        (word)
	);

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter realtime PERIOD = 40.0
)
(
	output logic clk
);

	initial
		clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk; // 40 ns period

endmodule

/* testbench/video_fetch_tb.sv */
`timescale 1ns/1ps

module video_fetch_tb
	import video_pkg::*;
;

	localparam int DEPTH = 4;
	localparam int NROWS = 12;

	typedef struct packed {
		logic [2:0] mode;
		logic       page;
		logic [2:0] mid_mode; // written while the frame is being fetched
		logic [3:0] lines;
		logic [7:0] grants;   // grants per line
	} row_t;

	logic clk, reset;
	logic psel, penable, pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata, prdata;
	logic pready, pslverr;
	logic line_start, int_start, vpix, fetch_en;
	logic dram_ack, dram_rvalid;
	logic [15:0] dram_rdata;
	logic dram_req, word_valid;
	logic [VADDR_W-1:0] dram_addr;
	fetch_word_t word;
	logic [2:0] typos;

	row_t table_rows [NROWS];
	logic [31:0] lcg_state = 32'h3f12;
	int error_count = 0;
	int grant_count = 0;
	int outstanding = 0;
	int cycles = 0;
	int limit;
	logic rvalid_seen = 1'b0; // dram_rvalid one cycle back
	logic [15:0] ret_q [$];  // data the DRAM model still owes
	logic [16:0] word_q [$]; // expected {data, kind} in grant order

	// reference state, mirrors the counters from the address rules
	logic [2:0]  ref_mode;
	logic        ref_page;
	logic [13:0] g_ref;
	logic [6:0]  tx_ref;
	logic [7:0]  ty_ref;

	tb_clock #(.PERIOD(40.0)) u_clock (.clk(clk));

	video_fetch_top #(.QUEUE_DEPTH(DEPTH)) uut (
		.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .line_start(line_start), .int_start(int_start), .vpix(vpix),
		.fetch_en(fetch_en), .dram_ack(dram_ack), .dram_rvalid(dram_rvalid),
		.dram_rdata(dram_rdata), .dram_req(dram_req), .dram_addr(dram_addr),
		.word_valid(word_valid), .word(word), .typos(typos)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 16;
	endfunction

	// expected DRAM address from the mode rules
	function automatic logic [VADDR_W-1:0] expected_addr(logic [2:0] m, logic pg,
		logic [13:0] g, logic [6:0] tx, logic [7:0] ty);
		logic [11:0] pix;
		logic [11:0] pix16;
		logic [11:0] attr;
		pix   = {g[12:11], g[7:5], g[10:8], g[4:1]};
		pix16 = {g[13:12], g[8:6], g[11:9], g[5:2]};
		attr  = {3'b110, g[12:8], g[4:1]};
		case (m)
			3'd0: return {6'b000001, pg, 2'b10, (g[0] ? attr : pix)};
			3'd1: return {6'b000001, pg, 1'b1, g[0], pix};
			3'd2: return {6'b000001, pg, ~g[0], g[1], pix16};
			3'd3, 3'd4: return {5'b00000, ~g[0], pg, 1'b1, g[1], g[13:2]};
			default: return {5'b00000, ~tx[0], pg, 1'b1, tx[1], 2'b00, ty[7:3], tx[6:2]};
		endcase
	endfunction

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic fail_plain(string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic next_cycle(int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// one APB transfer, setup then access
	task automatic apb_xfer(logic wr, logic [3:0] addr, logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		next_cycle(1);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		next_cycle(1);
		penable = 1'b1;
		@(negedge clk);
		check("pready", pready, 1);
		rdata = prdata;
		err   = pslverr;
		next_cycle(1);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// grant driver, random gap before each one-cycle ack
	initial
	begin
		int gap;
		gap = 0;
		forever
		begin
			next_cycle(1);
			if (dram_ack)
				dram_ack = 1'b0;
			else if (!reset && dram_req)
			begin
				if (gap == 0)
				begin
					dram_ack = 1'b1;
					gap = lcg_next() % 4;
				end
				else
					gap--;
			end
		end
	end

	// read returns in order, random latency up to 15
	initial
	begin
		int lat;
		lat = 0;
		forever
		begin
			next_cycle(1);
			dram_rvalid = 1'b0;
			if (ret_q.size() > 0)
			begin
				if (lat == 0)
				begin
					dram_rvalid = 1'b1;
					dram_rdata = ret_q.pop_front();
					lat = lcg_next() % 16;
				end
				else
					lat--;
			end
		end
	end

	// monitor, sampled mid-cycle where outputs are stable
	always @(negedge clk)
	begin
		logic [16:0] exp_word;
		logic kind;
		if (!reset)
		begin
			if (dram_req)
				check("outstanding below depth", outstanding < DEPTH, 1);
			if (dram_req && dram_ack)
			begin
				check("dram_addr", dram_addr,
					expected_addr(ref_mode, ref_page, g_ref, tx_ref, ty_ref));
				kind = (ref_mode == 3'd5) ? tx_ref[0] : g_ref[0];
				ret_q.push_back(dram_addr[15:0] ^ 16'h5a5a);
				word_q.push_back({dram_addr[15:0] ^ 16'h5a5a, kind});
				g_ref++;
				tx_ref++;
				grant_count++;
				outstanding++;
			end
			if (dram_rvalid)
				outstanding--;
			check("word_valid", word_valid, rvalid_seen); // one cycle after the return
			if (word_valid)
			begin
				if (word_q.size() == 0)
					fail_plain("word_valid seen with no read pending");
				exp_word = word_q.pop_front();
				check("word.data", word.data, exp_word[16:1]);
				check("word.kind", word.kind, exp_word[0]);
			end
			rvalid_seen = dram_rvalid;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("timeout: DRAM requests stopped completing");
			$display("Simulation failed");
			$fatal(1);
		end
	end

	initial
	begin
		logic [31:0] rd;
		logic err;
		int total;
		int target;
		table_rows[0]  = '{3'd0, 1'b0, 3'd2, 4'd1, 8'd64};
		table_rows[1]  = '{3'd0, 1'b1, 3'd5, 4'd1, 8'd64};
		table_rows[2]  = '{3'd1, 1'b0, 3'd0, 4'd1, 8'd48};
		table_rows[3]  = '{3'd1, 1'b1, 3'd3, 4'd1, 8'd48};
		table_rows[4]  = '{3'd2, 1'b0, 3'd4, 4'd1, 8'd48};
		table_rows[5]  = '{3'd2, 1'b1, 3'd0, 4'd1, 8'd48};
		table_rows[6]  = '{3'd3, 1'b0, 3'd1, 4'd1, 8'd40};
		table_rows[7]  = '{3'd3, 1'b1, 3'd5, 4'd1, 8'd40};
		table_rows[8]  = '{3'd4, 1'b0, 3'd2, 4'd1, 8'd40};
		table_rows[9]  = '{3'd4, 1'b1, 3'd0, 4'd1, 8'd40};
		table_rows[10] = '{3'd5, 1'b0, 3'd0, 4'd4, 8'd12};
		table_rows[11] = '{3'd5, 1'b1, 3'd3, 4'd3, 8'd10};
		total = 0;
		for (int i = 0; i < NROWS; i++)
			total += table_rows[i].lines * table_rows[i].grants;
		limit = total * 24 + 3000; // worst gap plus latency per grant, APB and setup margin
		reset = 1'b1;
		{psel, penable, pwrite, paddr, pwdata} = '0;
		{line_start, int_start, fetch_en, dram_ack, dram_rvalid} = '0;
		vpix = 1'b1;
		dram_rdata = '0;
		ref_mode = 3'd0;
		ref_page = 1'b0;
		g_ref = '0;
		tx_ref = '0;
		ty_ref = '0;
		repeat (5) @(posedge clk);
		#2 reset = 1'b0;
		check("dram_req", dram_req, 0);
		check("pslverr", pslverr, 0);

		// register access and error responses
		apb_xfer(1'b1, 4'h0, 32'd3, rd, err);
		check("pslverr", err, 0);
		apb_xfer(1'b1, 4'h4, 32'd1, rd, err);
		check("pslverr", err, 0);
		apb_xfer(1'b0, 4'h0, 32'd0, rd, err);
		check("prdata mode", rd, 3);
		apb_xfer(1'b0, 4'h4, 32'd0, rd, err);
		check("prdata page", rd, 1);
		apb_xfer(1'b1, 4'h0, 32'd6, rd, err);
		check("pslverr", err, 1);
		apb_xfer(1'b0, 4'h8, 32'd0, rd, err);
		check("pslverr", err, 1);
		apb_xfer(1'b0, 4'h0, 32'd0, rd, err);
		check("prdata mode", rd, 3);

		for (int r = 0; r < NROWS; r++)
		begin
			apb_xfer(1'b1, 4'h0, 32'(table_rows[r].mode), rd, err);
			apb_xfer(1'b1, 4'h4, 32'(table_rows[r].page), rd, err);
			apb_xfer(1'b0, 4'h0, 32'd0, rd, err);
			check("prdata mode", rd, 32'(table_rows[r].mode));
			next_cycle(1);
			int_start = 1'b1;
			ref_mode = table_rows[r].mode;
			ref_page = table_rows[r].page;
			g_ref = '0;
			ty_ref = 8'h37;
			next_cycle(1);
			int_start = 1'b0;
			@(negedge clk);
			check("typos", typos, 7);
			for (int l = 0; l < table_rows[r].lines; l++)
			begin
				next_cycle(1);
				line_start = 1'b1;
				next_cycle(1);
				line_start = 1'b0;
				next_cycle(1); // row count moves on the registered line_start
				ty_ref++;
				tx_ref = '0;
				@(negedge clk);
				check("typos", typos, 32'(ty_ref[2:0]));
				next_cycle(2);
				fetch_en = 1'b1;
				target = grant_count + table_rows[r].grants;
				if (l == 0)
				begin
					while (grant_count < target - table_rows[r].grants / 2)
						@(negedge clk);
					// mode change mid-frame must wait for the next frame
					apb_xfer(1'b1, 4'h0, 32'(table_rows[r].mid_mode), rd, err);
				end
				while (grant_count < target)
					@(negedge clk);
				next_cycle(1);
				fetch_en = 1'b0;
				next_cycle(2);
				while (dram_req || outstanding != 0 || word_q.size() != 0)
					@(negedge clk);
			end
		end

		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* src.f */
common/video_pkg.sv
source/video_apb_regs.sv
video/video_mode_decode.sv
video/video_addrgen.sv
video/video_fetch.sv
source/video_fetch_top.sv
testbench/tb_clock.sv
testbench/video_fetch_tb.sv

/* run.sh */
#!/bin/bash
# builds and runs the video fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module video_fetch_tb \
	--Mdir obj_dir -o sim_video_fetch > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_video_fetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi
